// File: logic/cpuPkg.sv
package cpuPkg;

    localparam int dataWidth = 32;     // bus and register word size
    localparam int numRegs = 16;
    localparam int regAddrWidth = 4;

    // decoded command opcodes
    typedef enum logic [3:0] {
        opLoad = 4'd0,   // cmdData -> MDR -> Ra
        opAdd  = 4'd1,
        opSub  = 4'd2,
        opAnd  = 4'd3,
        opOr   = 4'd4,
        opShl  = 4'd5,
        opShr  = 4'd6,   // logical
        opNeg  = 4'd7,   // Rc only
        opNot  = 4'd8,   // Rc only
        opMul  = 4'd9,   // 64-bit result into HI/LO
        opDiv  = 4'd10   // quotient in LO, remainder in HI
    } cpuOp;

endpackage

// File: logic/registerFile.sv
`timescale 1ns/1ps

module registerFile import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [regAddrWidth-1:0] regSel,
    input  logic                    writeEn,
    input  logic [dataWidth-1:0]    writeData,
    output logic [dataWidth-1:0]    readData
);

    logic [dataWidth-1:0] regs [numRegs];

    assign readData = regs[regSel];  // bus read port

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[regSel] <= writeData;
        end
    end

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu import cpuPkg::*; (
    input  cpuOp                 aluOp,
    input  logic [dataWidth-1:0] a,      // Y
    input  logic [dataWidth-1:0] b,      // bus
    output logic [dataWidth-1:0] result
);

    localparam int shWidth = $clog2(dataWidth);

    logic [shWidth-1:0] shAmt;

    assign shAmt = b[shWidth-1:0];

    always_comb begin
        case (aluOp)
            opAdd:   result = a + b;
            opSub:   result = a - b;
            opAnd:   result = a & b;
            opOr:    result = a | b;
            opShl:   result = a << shAmt;
            opShr:   result = a >> shAmt;  // zero fill
            opNeg:   result = -b;
            opNot:   result = ~b;
            default: result = '0;          // load, mul and div don't use the alu
        endcase
    end

endmodule

// File: logic/mulDiv.sv
`timescale 1ns/1ps

module mulDiv import cpuPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   isDiv,
    input  logic [dataWidth-1:0]   a,
    input  logic [dataWidth-1:0]   b,
    output logic                   done,
    output logic [2*dataWidth-1:0] product
);

    localparam int cntWidth = $clog2(dataWidth);

    logic                   busy;
    logic [cntWidth-1:0]    count;
    logic                   divMode;
    logic                   negRes;   // product or quotient sign
    logic                   negRem;   // remainder follows the dividend
    logic                   divZero;
    logic [dataWidth-1:0]   aMag;
    logic [dataWidth-1:0]   bMag;
    logic [dataWidth-1:0]   divisor;  // multiplicand for mul
    logic [dataWidth-1:0]   quo;      // multiplier bits for mul
    logic [dataWidth:0]     acc;
    logic [dataWidth:0]     sum;
    logic [dataWidth:0]     shifted;
    logic [dataWidth:0]     diff;
    logic [2*dataWidth-1:0] mulMag;
    logic [dataWidth-1:0]   quotient;
    logic [dataWidth-1:0]   remainder;

    assign aMag = a[dataWidth-1] ? -a : a;
    assign bMag = b[dataWidth-1] ? -b : b;

    assign sum = {1'b0, acc[dataWidth-1:0]} + (quo[0] ? {1'b0, divisor} : '0);
    assign shifted = {acc[dataWidth-1:0], quo[dataWidth-1]};
    assign diff = shifted - {1'b0, divisor};  // msb set means restore

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            count <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == cntWidth'(dataWidth - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            divMode <= isDiv;
            negRes <= a[dataWidth-1] ^ b[dataWidth-1];
            negRem <= a[dataWidth-1];
            divZero <= (b == '0);
            divisor <= bMag;
            quo <= aMag;
            acc <= '0;
        end else if (busy) begin
            if (divMode) begin
                if (diff[dataWidth]) begin
                    acc <= shifted;
                    quo <= {quo[dataWidth-2:0], 1'b0};
                end else begin
                    acc <= diff;
                    quo <= {quo[dataWidth-2:0], 1'b1};
                end
            end else begin
                acc <= {1'b0, sum[dataWidth:1]};          // shift {sum, quo} right
                quo <= {sum[0], quo[dataWidth-1:1]};
            end
        end
    end

    // sign fixup on the magnitude results
    assign mulMag = {acc[dataWidth-1:0], quo};
    assign quotient = divZero ? '1 : (negRes ? -quo : quo);
    assign remainder = negRem ? -acc[dataWidth-1:0] : acc[dataWidth-1:0];
    assign product = divMode ? {remainder, quotient} : (negRes ? -mulMag : mulMag);

endmodule

// File: logic/datapath.sv
`timescale 1ns/1ps

module datapath import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [dataWidth-1:0]    cmdData,
    input  logic                    mdrIn,
    input  logic                    regIn,
    input  logic                    regOutSel,
    input  logic [regAddrWidth-1:0] regSel,
    input  logic                    yIn,
    input  logic                    zIn,
    input  logic                    zLowOut,
    input  logic                    zHighOut,
    input  logic                    mdrOut,
    input  logic                    loIn,
    input  logic                    hiIn,
    input  cpuOp                    aluOp,
    input  logic                    mdStart,
    output logic                    mdDone,
    output logic [dataWidth-1:0]    busValue,
    output logic [dataWidth-1:0]    zLow,
    output logic [dataWidth-1:0]    zHigh,
    output logic [dataWidth-1:0]    loValue,
    output logic [dataWidth-1:0]    hiValue
);

    logic [dataWidth-1:0]   mdr;
    logic [dataWidth-1:0]   y;
    logic [dataWidth-1:0]   regRead;
    logic [dataWidth-1:0]   aluResult;
    logic [2*dataWidth-1:0] mdProduct;
    logic                   isDiv;
    logic                   isMd;

    assign isDiv = (aluOp == opDiv);
    assign isMd = (aluOp == opMul) || isDiv;

    // one driver at a time, the sequencer never raises two outs
    always_comb begin
        if (mdrOut) begin
            busValue = mdr;
        end else if (regOutSel) begin
            busValue = regRead;
        end else if (zLowOut) begin
            busValue = zLow;
        end else if (zHighOut) begin
            busValue = zHigh;
        end else begin
            busValue = '0;
        end
    end

    registerFile u_regs (
        .clk       (clk),
        .rst       (rst),
        .regSel    (regSel),
        .writeEn   (regIn),
        .writeData (busValue),
        .readData  (regRead)
    );

    alu u_alu (
        .aluOp  (aluOp),
        .a      (y),
        .b      (busValue),
        .result (aluResult)
    );

    mulDiv u_mulDiv (
        .clk     (clk),
        .rst     (rst),
        .start   (mdStart),
        .isDiv   (isDiv),
        .a       (y),
        .b       (busValue),
        .done    (mdDone),
        .product (mdProduct)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            mdr <= '0;
            y <= '0;
            zLow <= '0;
            zHigh <= '0;
            loValue <= '0;
            hiValue <= '0;
        end else begin
            if (mdrIn) mdr <= cmdData;
            if (yIn) y <= busValue;
            if (zIn) begin
                {zHigh, zLow} <= isMd ? mdProduct : {{dataWidth{1'b0}}, aluResult};
            end
            if (loIn) loValue <= busValue;
            if (hiIn) hiValue <= busValue;
        end
    end

endmodule

// File: logic/controlUnit.sv
`timescale 1ns/1ps

module controlUnit import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmdValid,
    input  cpuOp                    cmdOp,
    input  logic [regAddrWidth-1:0] cmdRa,
    input  logic [regAddrWidth-1:0] cmdRb,
    input  logic [regAddrWidth-1:0] cmdRc,
    input  logic                    mdDone,
    input  logic                    pushReady,
    output logic                    cmdReady,
    output logic                    mdrIn,
    output logic                    regIn,
    output logic                    regOutSel,
    output logic [regAddrWidth-1:0] regSel,
    output logic                    yIn,
    output logic                    zIn,
    output logic                    zLowOut,
    output logic                    zHighOut,
    output logic                    mdrOut,
    output logic                    loIn,
    output logic                    hiIn,
    output cpuOp                    aluOp,
    output logic                    mdStart,
    output logic                    pushValid,
    output logic                    resFromHiLo
);

    typedef enum logic [3:0] {
        idle, loadA, loadB, t3, t4, mdWait, t5, t6, push
    } ctrlState;

    ctrlState                state;
    ctrlState                nextState;
    cpuOp                    opQ;
    logic [regAddrWidth-1:0] raQ;
    logic [regAddrWidth-1:0] rbQ;
    logic [regAddrWidth-1:0] rcQ;
    logic                    isMd;

    assign isMd = (opQ == opMul) || (opQ == opDiv);
    assign aluOp = opQ;
    assign resFromHiLo = isMd;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            opQ <= opLoad;
            raQ <= '0;
            rbQ <= '0;
            rcQ <= '0;
        end else begin
            state <= nextState;
            if (cmdValid && cmdReady) begin  // latch the accepted command
                opQ <= cmdOp;
                raQ <= cmdRa;
                rbQ <= cmdRb;
                rcQ <= cmdRc;
            end
        end
    end

    always_comb begin
        nextState = state;
        cmdReady = 1'b0;
        mdrIn = 1'b0;
        regIn = 1'b0;
        regOutSel = 1'b0;
        regSel = raQ;
        yIn = 1'b0;
        zIn = 1'b0;
        zLowOut = 1'b0;
        zHighOut = 1'b0;
        mdrOut = 1'b0;
        loIn = 1'b0;
        hiIn = 1'b0;
        mdStart = 1'b0;
        pushValid = 1'b0;
        case (state)
            idle: begin
                cmdReady = 1'b1;
                if (cmdValid) nextState = (cmdOp == opLoad) ? loadA : t3;
            end
            loadA: begin
                mdrIn = 1'b1;
                nextState = loadB;
            end
            loadB: begin
                mdrOut = 1'b1;
                regIn = 1'b1;
                pushValid = 1'b1;
                nextState = pushReady ? idle : push;
            end
            t3: begin  // Rb -> Y
                regOutSel = 1'b1;
                regSel = rbQ;
                yIn = 1'b1;
                nextState = t4;
            end
            t4: begin  // Rc on the bus
                regOutSel = 1'b1;
                regSel = rcQ;
                if (isMd) begin
                    mdStart = 1'b1;
                    nextState = mdWait;
                end else begin
                    zIn = 1'b1;
                    nextState = t5;
                end
            end
            mdWait: begin
                if (mdDone) begin
                    zIn = 1'b1;
                    nextState = t5;
                end
            end
            t5: begin
                zLowOut = 1'b1;
                if (isMd) begin
                    loIn = 1'b1;
                    nextState = t6;
                end else begin
                    regIn = 1'b1;  // write back to Ra
                    pushValid = 1'b1;
                    nextState = pushReady ? idle : push;
                end
            end
            t6: begin
                zHighOut = 1'b1;
                hiIn = 1'b1;
                pushValid = 1'b1;
                nextState = pushReady ? idle : push;
            end
            push: begin
                // buffer was full, keep the result on the bus without writing
                mdrOut = (opQ == opLoad);
                zLowOut = (opQ != opLoad);
                pushValid = 1'b1;
                if (pushReady) nextState = idle;
            end
            default: nextState = idle;
        endcase
    end

endmodule

// File: logic/resultFifo.sv
`timescale 1ns/1ps

module resultFifo import cpuPkg::*; #(
    parameter int fifoDepth = 4  // power of two, at least 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 inValid,
    input  logic [dataWidth-1:0] inLo,
    input  logic [dataWidth-1:0] inHi,
    input  logic                 outReady,
    output logic                 inReady,
    output logic                 outValid,
    output logic [dataWidth-1:0] outLo,
    output logic [dataWidth-1:0] outHi
);

    localparam int ptrWidth = $clog2(fifoDepth);

    logic [dataWidth-1:0] memLo [fifoDepth];
    logic [dataWidth-1:0] memHi [fifoDepth];
    logic [ptrWidth-1:0]  wrPtr;
    logic [ptrWidth-1:0]  rdPtr;
    logic [ptrWidth:0]    count;
    logic                 doPush;
    logic                 doPop;

    assign inReady = (count != (ptrWidth + 1)'(fifoDepth));
    assign outValid = (count != '0);
    assign doPush = inValid && inReady;
    assign doPop = outValid && outReady;
    assign outLo = memLo[rdPtr];  // show-ahead head entry
    assign outHi = memHi[rdPtr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= wrPtr + 1'b1;  // wraps, depth is a power of two
            if (doPop) rdPtr <= rdPtr + 1'b1;
            count <= count + (ptrWidth + 1)'(doPush) - (ptrWidth + 1)'(doPop);
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            memLo[wrPtr] <= inLo;
            memHi[wrPtr] <= inHi;
        end
    end

endmodule

// File: logic/cpuTop.sv
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; #(
    parameter int fifoDepth = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmdValid,
    input  cpuOp                    cmdOp,
    input  logic [regAddrWidth-1:0] cmdRa,
    input  logic [regAddrWidth-1:0] cmdRb,
    input  logic [regAddrWidth-1:0] cmdRc,
    input  logic [dataWidth-1:0]    cmdData,
    input  logic                    resReady,
    output logic                    cmdReady,
    output logic                    resValid,
    output logic [dataWidth-1:0]    resLo,
    output logic [dataWidth-1:0]    resHi
);

    logic                    mdrIn;
    logic                    regIn;
    logic                    regOutSel;
    logic [regAddrWidth-1:0] regSel;
    logic                    yIn;
    logic                    zIn;
    logic                    zLowOut;
    logic                    zHighOut;
    logic                    mdrOut;
    logic                    loIn;
    logic                    hiIn;
    cpuOp                    aluOp;
    logic                    mdStart;
    logic                    mdDone;
    logic                    pushValid;
    logic                    pushReady;
    logic                    resFromHiLo;
    logic [dataWidth-1:0]    dataHold;
    logic [dataWidth-1:0]    busValue;
    logic [dataWidth-1:0]    zLow;
    logic [dataWidth-1:0]    zHigh;
    logic [dataWidth-1:0]    pushLo;
    logic [dataWidth-1:0]    pushHi;

    // load data has to survive until MDR takes it in loadA
    always_ff @(posedge clk) begin
        if (cmdValid && cmdReady) dataHold <= cmdData;
    end

    // Z holds the full HI/LO pair from t6 on
    assign pushLo = resFromHiLo ? zLow : busValue;
    assign pushHi = resFromHiLo ? zHigh : '0;

    controlUnit u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .cmdValid    (cmdValid),
        .cmdOp       (cmdOp),
        .cmdRa       (cmdRa),
        .cmdRb       (cmdRb),
        .cmdRc       (cmdRc),
        .mdDone      (mdDone),
        .pushReady   (pushReady),
        .cmdReady    (cmdReady),
        .mdrIn       (mdrIn),
        .regIn       (regIn),
        .regOutSel   (regOutSel),
        .regSel      (regSel),
        .yIn         (yIn),
        .zIn         (zIn),
        .zLowOut     (zLowOut),
        .zHighOut    (zHighOut),
        .mdrOut      (mdrOut),
        .loIn        (loIn),
        .hiIn        (hiIn),
        .aluOp       (aluOp),
        .mdStart     (mdStart),
        .pushValid   (pushValid),
        .resFromHiLo (resFromHiLo)
    );

    datapath u_dp (
        .clk       (clk),
        .rst       (rst),
        .cmdData   (dataHold),
        .mdrIn     (mdrIn),
        .regIn     (regIn),
        .regOutSel (regOutSel),
        .regSel    (regSel),
        .yIn       (yIn),
        .zIn       (zIn),
        .zLowOut   (zLowOut),
        .zHighOut  (zHighOut),
        .mdrOut    (mdrOut),
        .loIn      (loIn),
        .hiIn      (hiIn),
        .aluOp     (aluOp),
        .mdStart   (mdStart),
        .mdDone    (mdDone),
        .busValue  (busValue),
        .zLow      (zLow),
        .zHigh     (zHigh),
        .loValue   (),
        .hiValue   ()
    );

    resultFifo #(
        .fifoDepth (fifoDepth)
    ) u_fifo (
        .clk      (clk),
        .rst      (rst),
        .inValid  (pushValid),
        .inLo     (pushLo),
        .inHi     (pushHi),
        .outReady (resReady),
        .inReady  (pushReady),
        .outValid (resValid),
        .outLo    (resLo),
        .outHi    (resHi)
    );

endmodule

// File: test/tbCpu.sv
`timescale 1ns/1ps

module tbCpu import cpuPkg::*; ();

    localparam int numCmds = 300;
    localparam int cyclesPerCmd = 40;  // mul/div is the longest at about 38
    localparam int timeoutCycles = numCmds * cyclesPerCmd * 2;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    cmdValid;
    cpuOp                    cmdOp;
    logic [regAddrWidth-1:0] cmdRa;
    logic [regAddrWidth-1:0] cmdRb;
    logic [regAddrWidth-1:0] cmdRc;
    logic [dataWidth-1:0]    cmdData;
    logic                    resReady;
    logic                    cmdReady;
    logic                    resValid;
    logic [dataWidth-1:0]    resLo;
    logic [dataWidth-1:0]    resHi;

    logic [31:0]          lfsr = 32'ha1db;
    logic [dataWidth-1:0] shadow [numRegs];  // model of the register file
    logic [63:0]          expQ [$];          // {hi, lo} per accepted command
    int                   mismatches = 0;
    int                   otherErrors = 0;
    int                   cycleCount;
    logic                 stallEnable = 1'b0;
    logic                 readyLevel = 1'b1;
    int                   holdCount = 0;
    logic                 heldValid = 1'b0;  // head shown but not taken on the last edge
    logic [dataWidth-1:0] heldLo;
    logic [dataWidth-1:0] heldHi;

    always #4 clk = ~clk;

    cpuTop #(
        .fifoDepth (4)
    ) u_dut (
        .clk      (clk),
        .rst      (rst),
        .cmdValid (cmdValid),
        .cmdOp    (cmdOp),
        .cmdRa    (cmdRa),
        .cmdRb    (cmdRb),
        .cmdRc    (cmdRc),
        .cmdData  (cmdData),
        .resReady (resReady),
        .cmdReady (cmdReady),
        .resValid (resValid),
        .resLo    (resLo),
        .resHi    (resHi)
    );

    // galois lfsr stepped once per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return value;
    endfunction

    // expected {hi, lo} from the operand values
    function automatic logic [63:0] refResult(
        input cpuOp        op,
        input logic [31:0] rb,
        input logic [31:0] rc,
        input logic [31:0] data
    );
        longint      sb;
        longint      sc;
        longint      prod;
        logic [31:0] lo;
        sb = longint'($signed(rb));
        sc = longint'($signed(rc));
        lo = 32'h0;
        case (op)
            opLoad: lo = data;
            opAdd:  lo = rb + rc;
            opSub:  lo = rb - rc;
            opAnd:  lo = rb & rc;
            opOr:   lo = rb | rc;
            opShl:  lo = rb << rc[4:0];
            opShr:  lo = rb >> rc[4:0];
            opNeg:  lo = 32'h0 - rc;
            opNot:  lo = ~rc;
            opMul: begin
                prod = sb * sc;
                return prod;
            end
            opDiv: begin
                if (rc == 32'h0) return {rb, 32'hffff_ffff};
                return {32'(sb % sc), 32'(sb / sc)};  // truncates toward zero
            end
            default: lo = 32'h0;
        endcase
        return {32'h0, lo};
    endfunction

    task automatic sendCmd(
        input cpuOp                    op,
        input logic [regAddrWidth-1:0] ra,
        input logic [regAddrWidth-1:0] rb,
        input logic [regAddrWidth-1:0] rc,
        input logic [dataWidth-1:0]    data
    );
        logic [63:0] expected;
        @(posedge clk);
        cmdValid <= 1'b1;
        cmdOp <= op;
        cmdRa <= ra;
        cmdRb <= rb;
        cmdRc <= rc;
        cmdData <= data;
        @(posedge clk);
        while (!cmdReady) @(posedge clk);
        // accepted on this edge
        expected = refResult(op, shadow[rb], shadow[rc], data);
        if (op != opMul && op != opDiv) shadow[ra] = expected[31:0];
        expQ.push_back(expected);
        cmdValid <= 1'b0;
    endtask

    task automatic sendRandom(input cpuOp op);
        logic [regAddrWidth-1:0] ra;
        logic [regAddrWidth-1:0] rb;
        logic [regAddrWidth-1:0] rc;
        logic [dataWidth-1:0]    data;
        ra = regAddrWidth'(randBits(regAddrWidth));
        rb = regAddrWidth'(randBits(regAddrWidth));
        rc = regAddrWidth'(randBits(regAddrWidth));
        data = randBits(dataWidth);
        sendCmd(op, ra, rb, rc, data);
    endtask

    task automatic endSimulation();
        $display("Run finished: %0d mismatches, %0d other errors", mismatches, otherErrors);
        if (mismatches + otherErrors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    // result reader with long low stretches when stalling
    always @(negedge clk) begin
        if (!stallEnable) begin
            readyLevel = 1'b1;
            holdCount = 0;
        end else if (holdCount == 0) begin
            readyLevel = !readyLevel;
            holdCount = readyLevel ? 1 + randBits(3) : 16 + randBits(6);
        end else begin
            holdCount--;
        end
    end

    always @(posedge clk) resReady <= readyLevel;

    always @(posedge clk) begin : compare
        logic [63:0] expected;
        if (!rst && heldValid) begin
            assert (resValid) else begin
                $display("resValid dropped before the result was taken at %0t", $time);
                otherErrors++;
            end
            assert (resLo == heldLo) else begin
                $display("Mismatch resLo: got %h, held %h while stalled", resLo, heldLo);
                mismatches++;
            end
            assert (resHi == heldHi) else begin
                $display("Mismatch resHi: got %h, held %h while stalled", resHi, heldHi);
                mismatches++;
            end
        end
        if (!rst && resValid && resReady) begin
            if (expQ.size() == 0) begin
                $display("Result arrived with no command outstanding at %0t", $time);
                otherErrors++;
            end else begin
                expected = expQ.pop_front();
                assert (resLo == expected[31:0]) else begin
                    $display("Mismatch resLo: got %h, expected %h", resLo, expected[31:0]);
                    mismatches++;
                end
                assert (resHi == expected[63:32]) else begin
                    $display("Mismatch resHi: got %h, expected %h", resHi, expected[63:32]);
                    mismatches++;
                end
            end
        end
        heldValid = !rst && resValid && !resReady;
        heldLo = resLo;
        heldHi = resHi;
    end

    initial begin : watchdog
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Run timed out after %0d cycles with %0d results outstanding",
                 cycleCount, expQ.size());
        otherErrors++;
        endSimulation();
    end

    initial begin : stimulus
        logic [dataWidth-1:0] data;
        cpuOp                 op;
        rst = 1'b1;
        cmdValid = 1'b0;
        cmdOp = opLoad;
        cmdRa = '0;
        cmdRb = '0;
        cmdRc = '0;
        cmdData = '0;
        resReady = 1'b1;
        for (int r = 0; r < numRegs; r++) shadow[r] = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (cmdReady) else begin
            $display("cmdReady is not high after reset");
            otherErrors++;
        end
        assert (!resValid) else begin
            $display("resValid is high after reset with no command sent");
            otherErrors++;
        end

        // fixed load values first then random ones
        for (int r = 0; r < numRegs; r++) begin
            case (r)
                0: data = 32'h0;
                1: data = 32'h10;
                2: data = 32'hffff_fffe;
                default: data = randBits(32);
            endcase
            sendCmd(opLoad, regAddrWidth'(r), '0, '0, data);
        end
        for (int r = 0; r < numRegs; r++) begin
            sendCmd(opLoad, regAddrWidth'(r), '0, '0, randBits(32));
        end

        for (int i = 0; i < 100; i++) begin
            op = cpuOp'(4'(1 + randBits(3)));  // opAdd through opNot
            sendRandom(op);
        end

        sendCmd(opLoad, 4'd1, '0, '0, 32'd16);
        sendCmd(opLoad, 4'd2, '0, '0, 32'hffff_fffe);
        sendCmd(opDiv, 4'd0, 4'd1, 4'd2, '0);  // 16 / -2
        sendCmd(opMul, 4'd0, 4'd1, 4'd2, '0);
        sendCmd(opLoad, 4'd3, '0, '0, 32'hffff_fff9);
        sendCmd(opLoad, 4'd4, '0, '0, 32'd2);
        sendCmd(opDiv, 4'd0, 4'd3, 4'd4, '0);  // -7 / 2
        sendCmd(opDiv, 4'd0, 4'd3, 4'd2, '0);
        sendCmd(opLoad, 4'd5, '0, '0, 32'h0);
        sendCmd(opDiv, 4'd0, 4'd1, 4'd5, '0);
        sendCmd(opDiv, 4'd0, 4'd3, 4'd5, '0);  // negative dividend by zero
        sendCmd(opLoad, 4'd6, '0, '0, 32'h8000_0000);
        sendCmd(opMul, 4'd0, 4'd6, 4'd6, '0);
        sendCmd(opDiv, 4'd0, 4'd6, 4'd2, '0);
        for (int i = 0; i < 30; i++) begin
            op = randBits(1) ? opMul : opDiv;
            sendRandom(op);
        end

        // back-pressure long enough to fill the buffer and stall intake
        stallEnable = 1'b1;
        for (int i = 0; i < 110; i++) begin
            op = cpuOp'(4'(randBits(4) % 11));
            sendRandom(op);
        end
        stallEnable = 1'b0;

        while (expQ.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        assert (!resValid) else begin
            $display("Result buffer still holds an entry after all results arrived");
            otherErrors++;
        end
        assert (cmdReady) else begin
            $display("cmdReady is not high once the run is idle");
            otherErrors++;
        end
        endSimulation();
    end

endmodule

// File: compile.f
logic/cpuPkg.sv
logic/registerFile.sv
logic/alu.sv
logic/mulDiv.sv
logic/datapath.sv
logic/controlUnit.sv
logic/resultFifo.sv
logic/cpuTop.sv
test/tbCpu.sv

// File: Makefile
# Verilator simulation of the processor datapath testbench

VERILATOR ?= verilator
TOP       ?= tbCpu
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Errors found" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
